//--- Makefile
# Verilator build and run of the memory channel testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_chan
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "Simulation did not finish"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/mem_chan_dual_port.sv
// Memory channel with a stream port (mp0) and a single-word port (mp1)
// Both ports share one word memory; everything runs on sMCC_Ui_clk
`timescale 1ns/1ps
`default_nettype none

module mem_chan_dual_port
  import mem_chan_pkg::*;
(
  input  logic     sMCC_Ui_clk,
  input  logic     rst,
  // mp0 stream port
  input  mp_cmd_t  mp0_cmd,
  input  logic     mp0_cmd_valid,
  output logic     mp0_cmd_ready,
  input  mp_beat_t mp0_wr,
  input  logic     mp0_wr_valid,
  output logic     mp0_wr_ready,
  output mp_beat_t mp0_rd,
  output logic     mp0_rd_valid,
  input  logic     mp0_rd_ready,
  output mp_sts_t  mp0_sts,
  output logic     mp0_sts_valid,
  input  logic     mp0_sts_ready,
  // mp1 word port
  input  mem_req_t mp1_req,
  input  logic     mp1_req_valid,
  output logic     mp1_req_ready,
  output mem_rsp_t mp1_rsp,
  output logic     mp1_rsp_valid,
  input  logic     mp1_rsp_ready
);

  // --------------------
  // Mover to arbiter
  // --------------------
  mem_req_t     dm_req;
  logic         dm_req_valid;
  logic         dm_req_ready;
  mem_rsp_t     dm_rsp;
  logic         dm_rsp_valid;
  logic         dm_rsp_ready;

  // Arbiter to controller, tagged
  mem_tag_req_t mem_req;
  logic         mem_req_valid;
  logic         mem_req_ready;
  mem_tag_rsp_t mem_rsp;
  logic         mem_rsp_valid;
  logic         mem_rsp_ready;

  stream_data_mover stream_data_mover_inst (
    .sMCC_Ui_clk (sMCC_Ui_clk),
    .rst         (rst),
    .cmd         (mp0_cmd),
    .cmd_valid   (mp0_cmd_valid),
    .cmd_ready   (mp0_cmd_ready),
    .wr          (mp0_wr),
    .wr_valid    (mp0_wr_valid),
    .wr_ready    (mp0_wr_ready),
    .rd          (mp0_rd),
    .rd_valid    (mp0_rd_valid),
    .rd_ready    (mp0_rd_ready),
    .sts         (mp0_sts),
    .sts_valid   (mp0_sts_valid),
    .sts_ready   (mp0_sts_ready),
    .req         (dm_req),
    .req_valid   (dm_req_valid),
    .req_ready   (dm_req_ready),
    .rsp         (dm_rsp),
    .rsp_valid   (dm_rsp_valid),
    .rsp_ready   (dm_rsp_ready)
  );

  // mp1 enters the arbiter directly
  port_arbiter port_arbiter_inst (
    .sMCC_Ui_clk   (sMCC_Ui_clk),
    .rst           (rst),
    .mp0_req       (dm_req),
    .mp0_req_valid (dm_req_valid),
    .mp0_req_ready (dm_req_ready),
    .mp1_req       (mp1_req),
    .mp1_req_valid (mp1_req_valid),
    .mp1_req_ready (mp1_req_ready),
    .mp0_rsp       (dm_rsp),
    .mp0_rsp_valid (dm_rsp_valid),
    .mp0_rsp_ready (dm_rsp_ready),
    .mp1_rsp       (mp1_rsp),
    .mp1_rsp_valid (mp1_rsp_valid),
    .mp1_rsp_ready (mp1_rsp_ready),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_rsp       (mem_rsp),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_ready (mem_rsp_ready)
  );

  memory_ctrl memory_ctrl_inst (
    .sMCC_Ui_clk (sMCC_Ui_clk),
    .rst         (rst),
    .req         (mem_req),
    .req_valid   (mem_req_valid),
    .req_ready   (mem_req_ready),
    .rsp         (mem_rsp),
    .rsp_valid   (mem_rsp_valid),
    .rsp_ready   (mem_rsp_ready)
  );

endmodule

`default_nettype wire

//--- design/mem_chan_pkg.sv
// Opcode, port and FSM enums and the packed structs of every link
// Field widths come from the defines header
`default_nettype none

`include "mem_chan_defines.svh"

package mem_chan_pkg;

  // --------------------
  // Enums
  // --------------------
  typedef enum logic {
    MC_OP_READ  = 1'b0,
    MC_OP_WRITE = 1'b1
  } mc_op_e;

  // Tag that routes a response back to its port
  typedef enum logic {
    MC_PORT_MP0 = 1'b0,
    MC_PORT_MP1 = 1'b1
  } mc_port_e;

  // Data mover FSM, only the mover uses it
  typedef enum logic [1:0] {
    DM_IDLE,
    DM_WRITE,
    DM_READ,
    DM_STATUS
  } dm_state_e;

  // --------------------
  // mp0 stream port
  // --------------------
  typedef struct packed {
    mc_op_e                op;
    logic [`MC_ADDR_W-1:0] addr;
    logic [`MC_LEN_W-1:0]  len;
  } mp_cmd_t;

  typedef struct packed {
    logic [`MC_DATA_W-1:0] data;
    logic                  last;
  } mp_beat_t;

  // Wrap set when the burst crossed the top address
  typedef struct packed {
    mc_op_e               op;
    logic [`MC_LEN_W-1:0] len;
    logic                 wrap;
  } mp_sts_t;

  // --------------------
  // Word requests and responses
  // --------------------
  typedef struct packed {
    mc_op_e                op;
    logic [`MC_ADDR_W-1:0] addr;
    logic [`MC_DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    mc_port_e port;
    mem_req_t req;
  } mem_tag_req_t;

  // rdata is don't-care on a write response
  typedef struct packed {
    mc_op_e                op;
    logic [`MC_DATA_W-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    mc_port_e port;
    mem_rsp_t rsp;
  } mem_tag_rsp_t;

endpackage

`default_nettype wire

//--- design/memory_ctrl.sv
// Single-port word memory serving one request per cycle
// Responses come back in request order, one cycle after acceptance
// Write responses carry the old word as rdata, callers ignore it
`timescale 1ns/1ps
`default_nettype none

`include "mem_chan_defines.svh"

module memory_ctrl
  import mem_chan_pkg::*;
(
  input  logic         sMCC_Ui_clk,
  input  logic         rst,
  input  mem_tag_req_t req,
  input  logic         req_valid,
  output logic         req_ready,
  output mem_tag_rsp_t rsp,
  output logic         rsp_valid,
  input  logic         rsp_ready
);

  logic [`MC_DATA_W-1:0] mem_q [1 << `MC_ADDR_W];
  logic                  req_fire;

  // Accept only when the response stage is free or draining
  assign req_ready = !rsp_valid || rsp_ready;
  assign req_fire  = req_valid && req_ready;

  // --------------------
  // Array and response stage
  // --------------------
  always_ff @(posedge sMCC_Ui_clk) begin
    if (req_fire) begin
      if (req.req.op == MC_OP_WRITE) begin
        mem_q[req.req.addr] <= req.req.wdata;
      end
      // Tag and op travel with the data
      rsp.port      <= req.port;
      rsp.rsp.op    <= req.req.op;
      rsp.rsp.rdata <= mem_q[req.req.addr];
    end
  end

  always_ff @(posedge sMCC_Ui_clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else if (req_fire) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // Held response must not change under back-pressure
  a_rsp_stable: assert property (@(posedge sMCC_Ui_clk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

`default_nettype wire

//--- design/port_arbiter.sv
// Round-robin admission of mp0 and mp1 into one tagged request queue
// One request is admitted per cycle; responses are steered by their tag
`timescale 1ns/1ps
`default_nettype none

`include "mem_chan_defines.svh"

module port_arbiter
  import mem_chan_pkg::*;
(
  input  logic         sMCC_Ui_clk,
  input  logic         rst,
  input  mem_req_t     mp0_req,
  input  logic         mp0_req_valid,
  output logic         mp0_req_ready,
  input  mem_req_t     mp1_req,
  input  logic         mp1_req_valid,
  output logic         mp1_req_ready,
  output mem_rsp_t     mp0_rsp,
  output logic         mp0_rsp_valid,
  input  logic         mp0_rsp_ready,
  output mem_rsp_t     mp1_rsp,
  output logic         mp1_rsp_valid,
  input  logic         mp1_rsp_ready,
  output mem_tag_req_t mem_req,
  output logic         mem_req_valid,
  input  logic         mem_req_ready,
  input  mem_tag_rsp_t mem_rsp,
  input  logic         mem_rsp_valid,
  output logic         mem_rsp_ready
);

  localparam int PTR_W = $clog2(`MC_QUEUE_DEPTH);
  localparam logic [PTR_W:0] DEPTH = `MC_QUEUE_DEPTH;

  mem_tag_req_t     queue_q [`MC_QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             full;
  logic             push;
  logic             pop;
  mc_port_e         rr_q;
  mc_port_e         grant;

  // --------------------
  // Admission
  // --------------------
  // rr_q names the port that wins a tie
  always_comb begin
    if (mp0_req_valid && mp1_req_valid) begin
      grant = rr_q;
    end else if (mp1_req_valid) begin
      grant = MC_PORT_MP1;
    end else begin
      grant = MC_PORT_MP0;
    end
  end

  assign full          = count_q == DEPTH;
  assign mp0_req_ready = !full && (grant == MC_PORT_MP0);
  assign mp1_req_ready = !full && (grant == MC_PORT_MP1);
  assign push = (mp0_req_valid && mp0_req_ready) || (mp1_req_valid && mp1_req_ready);
  assign pop  = mem_req_valid && mem_req_ready;

  // Head of the queue goes to the controller
  assign mem_req       = queue_q[rd_ptr_q];
  assign mem_req_valid = count_q != '0;

  always_ff @(posedge sMCC_Ui_clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      rr_q     <= MC_PORT_MP0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
        // Turn passes to the other port
        rr_q     <= (grant == MC_PORT_MP0) ? MC_PORT_MP1 : MC_PORT_MP0;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + (PTR_W+1)'(1);
        2'b01:   count_q <= count_q - (PTR_W+1)'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Queue storage, tagged with the winning port
  always_ff @(posedge sMCC_Ui_clk) begin
    if (push) begin
      queue_q[wr_ptr_q] <= '{port: grant, req: (grant == MC_PORT_MP0) ? mp0_req : mp1_req};
    end
  end

  // --------------------
  // Response steering
  // --------------------
  assign mp0_rsp       = mem_rsp.rsp;
  assign mp1_rsp       = mem_rsp.rsp;
  assign mp0_rsp_valid = mem_rsp_valid && (mem_rsp.port == MC_PORT_MP0);
  assign mp1_rsp_valid = mem_rsp_valid && (mem_rsp.port == MC_PORT_MP1);
  assign mem_rsp_ready = (mem_rsp.port == MC_PORT_MP0) ? mp0_rsp_ready : mp1_rsp_ready;

  // Slot under the write pointer must not still hold an unread entry
  a_no_push_full: assert property (@(posedge sMCC_Ui_clk) disable iff (rst)
    push |-> !((wr_ptr_q == rd_ptr_q) && (count_q != '0)));

endmodule

`default_nettype wire

//--- design/stream_data_mover.sv
// Turns mp0 burst commands into single-word requests, one command at a time
// Write beats must arrive in order with last on beat len
// Addresses wrap to zero past the top word, reported in the status beat
`timescale 1ns/1ps
`default_nettype none

`include "mem_chan_defines.svh"

module stream_data_mover
  import mem_chan_pkg::*;
(
  input  logic     sMCC_Ui_clk,
  input  logic     rst,
  input  mp_cmd_t  cmd,
  input  logic     cmd_valid,
  output logic     cmd_ready,
  input  mp_beat_t wr,
  input  logic     wr_valid,
  output logic     wr_ready,
  output mp_beat_t rd,
  output logic     rd_valid,
  input  logic     rd_ready,
  output mp_sts_t  sts,
  output logic     sts_valid,
  input  logic     sts_ready,
  output mem_req_t req,
  output logic     req_valid,
  input  logic     req_ready,
  input  mem_rsp_t rsp,
  input  logic     rsp_valid,
  output logic     rsp_ready
);

  dm_state_e             state_q;
  mp_cmd_t               cmd_q;
  logic [`MC_LEN_W-1:0]  issue_cnt_q;
  logic [`MC_LEN_W-1:0]  rsp_cnt_q;
  logic                  issue_done_q;
  logic [`MC_ADDR_W-1:0] beat_off;
  logic [`MC_ADDR_W:0]   end_addr;
  logic                  req_fire;
  logic                  rsp_fire;
  logic                  last_rsp;

  // Offset of the next word, zero-extended to the address width
  assign beat_off = {{(`MC_ADDR_W-`MC_LEN_W){1'b0}}, issue_cnt_q};
  // Carry out of start plus len means the burst wrapped
  assign end_addr = {1'b0, cmd_q.addr} + {{(`MC_ADDR_W+1-`MC_LEN_W){1'b0}}, cmd_q.len};

  assign req_fire = req_valid && req_ready;
  assign rsp_fire = rsp_valid && rsp_ready;
  assign last_rsp = rsp_cnt_q == cmd_q.len;

  assign cmd_ready = state_q == DM_IDLE;

  // --------------------
  // Request side
  // --------------------
  always_comb begin
    req.op    = cmd_q.op;
    req.addr  = cmd_q.addr + beat_off;
    req.wdata = '0;
    req_valid = 1'b0;
    wr_ready  = 1'b0;
    case (state_q)
      // Each write beat goes straight out as one request
      DM_WRITE: begin
        req.wdata = wr.data;
        req_valid = wr_valid && !issue_done_q;
        wr_ready  = req_ready && !issue_done_q;
      end
      // Reads are issued back to back
      DM_READ: req_valid = !issue_done_q;
      default: req_valid = 1'b0;
    endcase
  end

  // --------------------
  // Response and status side
  // --------------------
  assign rd        = '{data: rsp.rdata, last: last_rsp};
  assign rd_valid  = (state_q == DM_READ) && rsp_valid;
  // Write responses are only counted, never stalled
  assign rsp_ready = (state_q == DM_READ) ? rd_ready : (state_q == DM_WRITE);

  assign sts       = '{op: cmd_q.op, len: cmd_q.len, wrap: end_addr[`MC_ADDR_W]};
  assign sts_valid = state_q == DM_STATUS;

  always_ff @(posedge sMCC_Ui_clk) begin
    if (rst) begin
      state_q      <= DM_IDLE;
      issue_cnt_q  <= '0;
      rsp_cnt_q    <= '0;
      issue_done_q <= 1'b0;
    end else begin
      case (state_q)
        DM_IDLE: begin
          if (cmd_valid) begin
            state_q      <= (cmd.op == MC_OP_WRITE) ? DM_WRITE : DM_READ;
            issue_cnt_q  <= '0;
            rsp_cnt_q    <= '0;
            issue_done_q <= 1'b0;
          end
        end
        DM_WRITE, DM_READ: begin
          if (req_fire) begin
            issue_cnt_q <= issue_cnt_q + `MC_LEN_W'(1);
            if (issue_cnt_q == cmd_q.len) begin
              issue_done_q <= 1'b1;
            end
          end
          // Done once the final beat's response is back
          if (rsp_fire) begin
            rsp_cnt_q <= rsp_cnt_q + `MC_LEN_W'(1);
            if (last_rsp) begin
              state_q <= DM_STATUS;
            end
          end
        end
        DM_STATUS: begin
          if (sts_ready) begin
            state_q <= DM_IDLE;
          end
        end
        default: state_q <= DM_IDLE;
      endcase
    end
  end

  // Command payload, held for the whole burst
  always_ff @(posedge sMCC_Ui_clk) begin
    if (cmd_valid && cmd_ready) begin
      cmd_q <= cmd;
    end
  end

  // Upstream framing must agree with the command length
  a_wr_last_on_len: assert property (@(posedge sMCC_Ui_clk) disable iff (rst)
    wr_valid && wr_ready && wr.last |-> issue_cnt_q == cmd_q.len);

endmodule

`default_nettype wire

//--- dv/tb_mem_chan.sv
// Random traffic on both ports of the memory channel, checked against a word model
// Only addresses written earlier are read back, the memory powers up unknown
// Every handshake is sampled 1 ns after the falling edge
`timescale 1ns/1ps
`default_nettype none

`include "mem_chan_defines.svh"

module tb_mem_chan
  import mem_chan_pkg::*;
();

  localparam int TIMEOUT = 2000;
  localparam int WORDS   = 1 << `MC_ADDR_W;

  logic     sMCC_Ui_clk;
  logic     rst;
  mp_cmd_t  mp0_cmd;
  logic     mp0_cmd_valid;
  logic     mp0_cmd_ready;
  mp_beat_t mp0_wr;
  logic     mp0_wr_valid;
  logic     mp0_wr_ready;
  mp_beat_t mp0_rd;
  logic     mp0_rd_valid;
  logic     mp0_rd_ready;
  mp_sts_t  mp0_sts;
  logic     mp0_sts_valid;
  logic     mp0_sts_ready;
  mem_req_t mp1_req;
  logic     mp1_req_valid;
  logic     mp1_req_ready;
  mem_rsp_t mp1_rsp;
  logic     mp1_rsp_valid;
  logic     mp1_rsp_ready;

  logic [31:0]           lfsr_q;
  logic                  bp_on;
  int                    err_cnt;
  int                    check_cnt;
  int                    test_cnt;
  int                    err_base;
  logic [`MC_DATA_W-1:0] model [WORDS];

  mem_chan_dual_port mem_chan_dual_port_inst (.*);

  always #20 sMCC_Ui_clk = ~sMCC_Ui_clk;

  // --------------------
  // Random source
  // --------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Ready is random only while back-pressure is on
  task automatic rand_ready(output logic r);
    logic [31:0] v;
    r = 1'b1;
    if (bp_on) begin
      rand_bits(1, v);
      r = v[0];
    end
  endtask

  // --------------------
  // Checks and report
  // --------------------
  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    check_cnt++;
    if (got !== exp) begin
      $display("ERR %0t ns: %s got %h expected %h", $time, msg, got, exp);
      err_cnt++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    $display("ERRORS FOUND");
    $finish;
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (err_cnt == err_base) $display("TEST %s: ok", name);
    else $display("TEST %s: %0d mismatches", name, err_cnt - err_base);
    err_base = err_cnt;
  endtask

  // --------------------
  // mp0 stream port
  // --------------------
  task automatic mp0_command(input mc_op_e op, input logic [9:0] addr, input logic [3:0] len);
    @(negedge sMCC_Ui_clk);
    mp0_cmd       = '{op: op, addr: addr, len: len};
    mp0_cmd_valid = 1'b1;
    for (int t = 0; ; t++) begin
      #1;
      if (mp0_cmd_ready) break;
      if (t > TIMEOUT) abort_run("mp0 command accept");
      @(negedge sMCC_Ui_clk);
    end
    @(negedge sMCC_Ui_clk);
    mp0_cmd_valid = 1'b0;
  endtask

  // Wrap expected when start plus len runs past the top word
  task automatic mp0_status(input mc_op_e op, input logic [9:0] addr, input logic [3:0] len);
    logic r;
    for (int t = 0; ; t++) begin
      @(negedge sMCC_Ui_clk);
      rand_ready(r);
      mp0_sts_ready = r;
      #1;
      if (mp0_sts_valid && r) break;
      if (t > TIMEOUT) abort_run("mp0 status beat");
    end
    check_eq(32'(mp0_sts.op), 32'(op), "status op");
    check_eq(32'(mp0_sts.len), 32'(len), "status len");
    check_eq(32'(mp0_sts.wrap), 32'(int'(addr) + int'(len) >= WORDS), "status wrap");
    @(negedge sMCC_Ui_clk);
    mp0_sts_ready = 1'b0;
  endtask

  task automatic mp0_write_burst(input logic [9:0] addr, input logic [3:0] len);
    logic [31:0] d;
    mp0_command(MC_OP_WRITE, addr, len);
    for (int i = 0; i <= int'(len); i++) begin
      rand_bits(32, d);
      @(negedge sMCC_Ui_clk);
      mp0_wr       = '{data: d, last: (i == int'(len))};
      mp0_wr_valid = 1'b1;
      for (int t = 0; ; t++) begin
        #1;
        if (mp0_wr_ready) break;
        if (t > TIMEOUT) abort_run("mp0 write beat accept");
        @(negedge sMCC_Ui_clk);
      end
      model[addr + 10'(i)] = d;
    end
    @(negedge sMCC_Ui_clk);
    mp0_wr_valid = 1'b0;
    mp0_status(MC_OP_WRITE, addr, len);
  endtask

  // Exactly len+1 beats, last only on the final one
  task automatic mp0_read_burst(input logic [9:0] addr, input logic [3:0] len);
    logic r;
    mp0_command(MC_OP_READ, addr, len);
    for (int i = 0; i <= int'(len); i++) begin
      for (int t = 0; ; t++) begin
        @(negedge sMCC_Ui_clk);
        rand_ready(r);
        mp0_rd_ready = r;
        #1;
        if (mp0_rd_valid && r) break;
        if (t > TIMEOUT) abort_run("mp0 read beat");
      end
      check_eq(mp0_rd.data, model[addr + 10'(i)], "mp0 read data");
      check_eq(32'(mp0_rd.last), 32'(i == int'(len)), "mp0 read last");
    end
    @(negedge sMCC_Ui_clk);
    mp0_rd_ready = 1'b0;
    mp0_status(MC_OP_READ, addr, len);
  endtask

  // --------------------
  // mp1 word port
  // --------------------
  task automatic mp1_access(input mc_op_e op, input logic [9:0] addr, input logic [31:0] d);
    logic r;
    @(negedge sMCC_Ui_clk);
    mp1_req       = '{op: op, addr: addr, wdata: d};
    mp1_req_valid = 1'b1;
    for (int t = 0; ; t++) begin
      #1;
      if (mp1_req_ready) break;
      if (t > TIMEOUT) abort_run("mp1 request accept");
      @(negedge sMCC_Ui_clk);
    end
    if (op == MC_OP_WRITE) model[addr] = d;
    for (int t = 0; ; t++) begin
      @(negedge sMCC_Ui_clk);
      mp1_req_valid = 1'b0;
      rand_ready(r);
      mp1_rsp_ready = r;
      #1;
      if (mp1_rsp_valid && r) break;
      if (t > TIMEOUT) abort_run("mp1 response");
    end
    check_eq(32'(mp1_rsp.op), 32'(op), "mp1 response op");
    if (op == MC_OP_READ) check_eq(mp1_rsp.rdata, model[addr], "mp1 read data");
    @(negedge sMCC_Ui_clk);
    mp1_rsp_ready = 1'b0;
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [31:0] v;
    logic [9:0]  b_addr [4];
    logic [3:0]  b_len [4];
    logic [9:0]  w_addr [8];
    sMCC_Ui_clk   = 1'b0;
    rst           = 1'b1;
    mp0_cmd       = '0;
    mp0_cmd_valid = 1'b0;
    mp0_wr        = '0;
    mp0_wr_valid  = 1'b0;
    mp0_rd_ready  = 1'b0;
    mp0_sts_ready = 1'b0;
    mp1_req       = '0;
    mp1_req_valid = 1'b0;
    mp1_rsp_ready = 1'b0;
    lfsr_q        = 32'h9d3ba0cd;
    bp_on         = 1'b0;
    err_cnt       = 0;
    check_cnt     = 0;
    test_cnt      = 0;
    err_base      = 0;

    // Valids low through reset and one cycle after
    for (int c = 0; c < 3; c++) begin
      @(negedge sMCC_Ui_clk);
      if (c == 1) rst = 1'b0;
      #1;
      check_eq(32'(mp0_rd_valid), 0, "mp0_rd_valid after reset");
      check_eq(32'(mp0_sts_valid), 0, "mp0_sts_valid after reset");
      check_eq(32'(mp1_rsp_valid), 0, "mp1_rsp_valid after reset");
    end
    finish_test("reset");

    // Bursts kept below address 512, no wrap
    for (int k = 0; k < 4; k++) begin
      rand_bits(9, v);
      b_addr[k] = {1'b0, v[8:0]};
      rand_bits(4, v);
      b_len[k] = v[3:0];
      mp0_write_burst(b_addr[k], b_len[k]);
    end
    for (int k = 0; k < 4; k++) mp0_read_burst(b_addr[k], b_len[k]);
    finish_test("mp0 write then read");

    // Start within 5 words of the top, at least 9 beats
    rand_bits(5, v);
    b_addr[0] = 10'h3fb + 10'(v[1:0]);
    b_len[0]  = 4'd8 + 4'(v[4:2]);
    mp0_write_burst(b_addr[0], b_len[0]);
    mp0_read_burst(b_addr[0], b_len[0]);
    finish_test("wrapping burst");

    for (int k = 0; k < 4; k++) begin
      rand_bits(32, v);
      mp1_access(MC_OP_WRITE, 10'h100 + 10'(k), v);
    end
    mp0_read_burst(10'h100, 4'd3);
    mp0_write_burst(10'h180, 4'd5);
    for (int k = 0; k < 6; k++) mp1_access(MC_OP_READ, 10'h180 + 10'(k), 32'h0);
    finish_test("shared memory");

    // mp0 in the low half, mp1 in the high half
    bp_on = 1'b1;
    fork
      begin
        for (int k = 0; k < 3; k++) begin
          rand_bits(12, v);
          b_addr[k] = {2'b00, v[7:0]};
          b_len[k]  = v[11:8];
          mp0_write_burst(b_addr[k], b_len[k]);
        end
        for (int k = 0; k < 3; k++) mp0_read_burst(b_addr[k], b_len[k]);
      end
      begin
        for (int k = 0; k < 8; k++) begin
          rand_bits(9, v);
          w_addr[k] = {1'b1, v[8:0]};
          rand_bits(32, v);
          mp1_access(MC_OP_WRITE, w_addr[k], v);
        end
        for (int k = 0; k < 8; k++) mp1_access(MC_OP_READ, w_addr[k], 32'h0);
      end
    join
    bp_on = 1'b0;
    finish_test("concurrent traffic");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
design/mem_chan_pkg.sv
design/stream_data_mover.sv
design/port_arbiter.sv
design/memory_ctrl.sv
design/mem_chan_dual_port.sv
dv/tb_mem_chan.sv

//--- include/mem_chan_defines.svh
// Sizing of the memory channel, shared by the package and the RTL
// MC_LEN_W sets the longest mp0 burst to 2**MC_LEN_W beats
// MC_QUEUE_DEPTH must be a power of two and no less than 2
`ifndef MEM_CHAN_DEFINES_SVH
`define MEM_CHAN_DEFINES_SVH

// --------------------
// Memory geometry
// --------------------

// Word address width, the memory holds 2**MC_ADDR_W words
`define MC_ADDR_W 10

// Word width, full words only
`define MC_DATA_W 32

// --------------------
// Burst and queue sizing
// --------------------

// Burst length field, the command carries beats minus one
`define MC_LEN_W 4

// Request entries held in the port arbiter
`define MC_QUEUE_DEPTH 4

`endif
